// File: include/eeprom_macros.svh
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// array geometry
`define EEPROM_ADDR_W 11
`define EEPROM_DEPTH 2048

// upper nibble of every control byte
`define EEPROM_DEV_CODE 4'b1010

// entries in the command and read-result queues
`define EEPROM_QUEUE_DEPTH 4

// CLK cycles per SCL period, split into quarters by the master
`define EEPROM_BIT_CYCLES 4

`endif

// File: source/eeprom_pkg.sv
`include "eeprom_macros.svh"

package eeprom_pkg;

    // one queued request from the user side
    typedef struct packed {
        logic                       write; // 0 = random read
        logic [`EEPROM_ADDR_W-1:0]  addr;
        logic [7:0]                 wdata; // don't care on reads
    } eeprom_cmd_t;

    typedef struct packed {
        logic [`EEPROM_ADDR_W-1:0]  addr;
        logic [7:0]                 rdata;
    } eeprom_rd_t;

    // bus transaction phases, shared by master and device
    typedef enum logic [3:0] {
        ph_idle,
        ph_start,
        ph_ctrl,
        ph_addr,
        ph_wdata,
        ph_restart,
        ph_rctrl,
        ph_rdata,
        ph_stop
    } bus_phase_t;

endpackage

// File: source/byte_queue.sv
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module byte_queue #(
    parameter type item_t = logic [7:0]
) (
    input  logic  CLK,
    input  logic  RESET,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t head,
    output logic  full,
    output logic  empty
);
    localparam int depth = `EEPROM_QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);

    item_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // overflow drops the item
    assign do_pop  = pop && !empty;
    assign full    = (count == (ptr_w+1)'(depth));
    assign empty   = (count == '0);
    assign head    = mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_item;
    end

endmodule

// File: source/eeprom_serial_master.sv
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_serial_master (
    input  logic                    CLK,
    input  logic                    RESET,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    input  logic                    cmd_ready,
    input  logic                    rd_full,
    output logic                    cmd_take,
    output logic                    done,
    output logic                    rd_valid,
    output eeprom_pkg::eeprom_rd_t  rd_result,
    output logic                    idle,
    output logic                    scl,
    output logic                    sda_drive_low,
    input  logic                    sda
);
    import eeprom_pkg::*;

    localparam int q_w = $clog2(`EEPROM_BIT_CYCLES);
    localparam logic [q_w-1:0] q_last = q_w'(`EEPROM_BIT_CYCLES - 1);
    localparam logic [q_w-1:0] q_mid  = q_w'(`EEPROM_BIT_CYCLES / 2);

    bus_phase_t  phase;
    bus_phase_t  next_phase;
    logic [q_w-1:0] q;           // quarter within the current bit
    logic [3:0]  bit_cnt;        // 8 data bits then the ack slot
    logic [7:0]  sh;
    eeprom_cmd_t cur;
    logic        bit_end;
    logic        byte_phase;
    logic        phase_done;
    logic        scl_hi;

    // no new read while a result would find the read queue full
    assign cmd_take   = (phase == ph_idle) && !done && cmd_ready && (cmd.write || !rd_full);
    assign idle       = (phase == ph_idle) && !done;
    assign bit_end    = (q == q_last);
    assign scl_hi     = (q != '0) && (q != q_last);
    assign byte_phase = (phase == ph_ctrl) || (phase == ph_addr) || (phase == ph_wdata) ||
                        (phase == ph_rctrl) || (phase == ph_rdata);
    assign phase_done = !byte_phase || (bit_cnt == 4'd8);

    assign rd_result.addr  = cur.addr;
    assign rd_result.rdata = sh;

    always_comb
    begin
        case (phase)
            ph_start:   next_phase = ph_ctrl;
            ph_ctrl:    next_phase = ph_addr;
            ph_addr:    next_phase = cur.write ? ph_wdata : ph_restart;
            ph_wdata:   next_phase = ph_stop;
            ph_restart: next_phase = ph_rctrl;
            ph_rctrl:   next_phase = ph_rdata;
            ph_rdata:   next_phase = ph_stop;
            default:    next_phase = ph_idle;
        endcase
    end

    // SCL and SDA shapes per phase; SDA moves in quarter 0 of normal bits
    always_comb
    begin
        case (phase)
            ph_idle:
            begin
                scl           = 1'b1;
                sda_drive_low = 1'b0;
            end
            ph_start:
            begin
                scl           = (q != q_last);
                sda_drive_low = (q >= q_mid);  // falls with SCL high
            end
            ph_restart:
            begin
                scl           = scl_hi;
                sda_drive_low = (q >= q_mid);
            end
            ph_stop:
            begin
                scl           = (q != '0);
                sda_drive_low = (q < q_mid);   // rises with SCL high
            end
            ph_rdata:
            begin
                scl           = scl_hi;
                sda_drive_low = 1'b0;          // device data, then our nack
            end
            default:
            begin
                scl           = scl_hi;
                sda_drive_low = (bit_cnt != 4'd8) && !sh[7];
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase    <= ph_idle;
            q        <= '0;
            bit_cnt  <= '0;
            done     <= 1'b0;
            rd_valid <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;
            rd_valid <= 1'b0;
            if (cmd_take)
            begin
                phase   <= ph_start;
                q       <= '0;
                bit_cnt <= '0;
            end
            else if (phase != ph_idle)
            begin
                q <= bit_end ? '0 : q + 1'b1;
                if (bit_end && !phase_done)
                    bit_cnt <= bit_cnt + 1'b1;
                else if (bit_end)
                begin
                    bit_cnt <= '0;
                    phase   <= next_phase;
                    if (phase == ph_stop)
                    begin
                        done     <= 1'b1;
                        rd_valid <= !cur.write;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_take)
            cur <= cmd;
        if (phase == ph_rdata && q == q_mid && bit_cnt != 4'd8)
            sh <= {sh[6:0], sda};  // sample while SCL is high
        else if (bit_end && phase_done)
        begin
            case (next_phase)
                ph_ctrl:  sh <= {`EEPROM_DEV_CODE, cur.addr[`EEPROM_ADDR_W-1:8], 1'b0};
                ph_addr:  sh <= cur.addr[7:0];
                ph_wdata: sh <= cur.wdata;
                ph_rctrl: sh <= {`EEPROM_DEV_CODE, cur.addr[`EEPROM_ADDR_W-1:8], 1'b1};
                default:  sh <= sh;  // keep read byte through stop
            endcase
        end
        else if (bit_end && phase != ph_rdata)
            sh <= {sh[6:0], 1'b0};
    end

endmodule

// File: source/eeprom_device.sv
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_device (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low
);
    import eeprom_pkg::*;

    bus_phase_t                phase;
    logic [3:0]                bit_cnt;  // SCL rises seen in this byte
    logic [7:0]                sh;
    logic [`EEPROM_ADDR_W-1:0] ptr;
    logic [7:0]                mem [`EEPROM_DEPTH];
    logic                      scl_q;
    logic                      sda_q;
    logic                      rise;
    logic                      fall;
    logic                      start_c;
    logic                      stop_c;
    logic                      hit;
    logic                      byte_end;

    assign rise     = scl && !scl_q;
    assign fall     = !scl && scl_q;
    assign start_c  = scl && scl_q && sda_q && !sda;
    assign stop_c   = scl && scl_q && !sda_q && sda;
    assign hit      = (sh[7:4] == `EEPROM_DEV_CODE);
    assign byte_end = fall && (bit_cnt == 4'd8) && (phase != ph_idle);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase         <= ph_idle;
            bit_cnt       <= '0;
            sda_drive_low <= 1'b0;
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_c)
            begin
                phase         <= ph_ctrl;
                bit_cnt       <= '0;
                sda_drive_low <= 1'b0;
            end
            else if (stop_c)
            begin
                phase         <= ph_idle;
                sda_drive_low <= 1'b0;
            end
            else if (phase != ph_idle && rise)
                bit_cnt <= bit_cnt + 1'b1;
            else if (phase != ph_idle && fall)
            begin
                if (bit_cnt == 4'd9)  // end of ack slot
                begin
                    bit_cnt       <= '0;
                    sda_drive_low <= 1'b0;
                    case (phase)
                        ph_ctrl:
                            if (!hit)
                                phase <= ph_idle;
                            else if (sh[0])
                            begin
                                phase         <= ph_rdata;
                                sda_drive_low <= ~mem[ptr][7];
                            end
                            else
                                phase <= ph_addr;
                        ph_addr: phase <= ph_wdata;
                        default: phase <= ph_idle;  // wait for stop
                    endcase
                end
                else if (phase == ph_rdata)
                    sda_drive_low <= (bit_cnt < 4'd8) ? ~sh[6] : 1'b0;
                else if (bit_cnt == 4'd8)
                    sda_drive_low <= hit || (phase != ph_ctrl);  // ack
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rise && phase != ph_rdata && bit_cnt < 4'd8)
            sh <= {sh[6:0], sda};
        else if (fall && phase == ph_rdata && bit_cnt < 4'd8)
            sh <= {sh[6:0], 1'b0};
        else if (fall && phase == ph_ctrl && bit_cnt == 4'd9 && hit && sh[0])
            sh <= mem[ptr];
        if (byte_end && phase == ph_ctrl && hit)
            ptr[`EEPROM_ADDR_W-1:8] <= sh[3:1];
        if (byte_end && phase == ph_addr)
            ptr[7:0] <= sh;
        if (byte_end && phase == ph_wdata)
            mem[ptr] <= sh;
    end

endmodule

// File: source/eeprom_subsystem.sv
`timescale 1ns/10ps

module eeprom_subsystem (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cmd_push,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    output logic                    cmd_full,
    input  logic                    rd_pop,
    output eeprom_pkg::eeprom_rd_t  rd_data,
    output logic                    rd_empty,
    output logic                    idle
);
    import eeprom_pkg::*;

    eeprom_cmd_t cmd_head;
    eeprom_rd_t  rd_result;
    logic        cmd_empty;
    logic        cmd_take;
    logic        rd_full;
    logic        done;
    logic        rd_valid;
    logic        scl;
    logic        sda;
    logic        sda_drive_low;
    logic        dev_sda_drive_low;

    // open-drain wired AND
    assign sda = ~(sda_drive_low | dev_sda_drive_low);

    byte_queue #(.item_t(eeprom_cmd_t)) cmd_queue0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (cmd_push),
        .push_item (cmd),
        .pop       (cmd_take),
        .head      (cmd_head),
        .full      (cmd_full),
        .empty     (cmd_empty)
    );

    eeprom_serial_master master0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd           (cmd_head),
        .cmd_ready     (~cmd_empty),
        .rd_full       (rd_full),
        .cmd_take      (cmd_take),
        .done          (done),
        .rd_valid      (rd_valid),
        .rd_result     (rd_result),
        .idle          (idle),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda           (sda)
    );

    byte_queue #(.item_t(eeprom_rd_t)) rd_queue0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (done & rd_valid),
        .push_item (rd_result),
        .pop       (rd_pop),
        .head      (rd_data),
        .full      (rd_full),
        .empty     (rd_empty)
    );

    eeprom_device device0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda),
        .sda_drive_low (dev_sda_drive_low)
    );

endmodule

// File: testbench/eeprom_properties.sv
`timescale 1ns/10ps

module eeprom_properties (
    input logic                   CLK,
    input logic                   RESET,
    input logic                   scl,
    input logic                   sda,
    input eeprom_pkg::bus_phase_t phase,
    input logic                   done,
    input logic                   rd_valid,
    input logic                   rd_full
);
    import eeprom_pkg::*;

    done_single_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // with SCL high only start, repeated start and stop may move SDA
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda != $past(sda))) |->
            (phase inside {ph_start, ph_restart, ph_stop}))
        else $error("sda changed while scl was high outside start, restart or stop");

    no_result_when_full: assert property (@(posedge CLK) disable iff (RESET)
        rd_valid |-> !rd_full)
        else $error("read result issued while the read queue was full");

endmodule

bind eeprom_serial_master eeprom_properties props0 (
    .CLK      (CLK),
    .RESET    (RESET),
    .scl      (scl),
    .sda      (sda),
    .phase    (phase),
    .done     (done),
    .rd_valid (rd_valid),
    .rd_full  (rd_full)
);

// File: testbench/eeprom_tb.sv
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_tb;
    import eeprom_pkg::*;

    typedef struct packed {
        eeprom_cmd_t cmd;
        logic [7:0]  exp;  // expected byte on reads
    } entry_t;

    localparam int timeout_cycles = 10000;

    logic                      CLK;
    logic                      RESET;
    logic                      cmd_push;
    eeprom_cmd_t               cmd;
    logic                      cmd_full;
    logic                      rd_pop;
    eeprom_rd_t                rd_data;
    logic                      rd_empty;
    logic                      idle;
    logic                      pop_enable;
    logic [7:0]                model [`EEPROM_DEPTH];
    logic [`EEPROM_ADDR_W-1:0] waddr [8];
    entry_t                    stim [$];
    eeprom_rd_t                exp_q [$];
    integer                    seed;
    integer                    errors;
    integer                    checks;

    eeprom_subsystem dut0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd_push (cmd_push),
        .cmd      (cmd),
        .cmd_full (cmd_full),
        .rd_pop   (rd_pop),
        .rd_data  (rd_data),
        .rd_empty (rd_empty),
        .idle     (idle)
    );

    always #50 CLK = ~CLK;

    task automatic check_rd(input string name, input eeprom_rd_t got, input eeprom_rd_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got addr %h data %h, expected addr %h data %h",
                     name, got.addr, got.rdata, exp.addr, exp.rdata);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic add_write(input logic [`EEPROM_ADDR_W-1:0] a, input logic [7:0] d);
        entry_t e;
        e.cmd.write = 1'b1;
        e.cmd.addr  = a;
        e.cmd.wdata = d;
        e.exp       = 8'h00;
        model[a]    = d;
        stim.push_back(e);
    endtask

    task automatic add_read(input logic [`EEPROM_ADDR_W-1:0] a);
        entry_t e;
        e.cmd.write = 1'b0;
        e.cmd.addr  = a;
        e.cmd.wdata = 8'h00;
        e.exp       = model[a];
        stim.push_back(e);
    endtask

    task automatic pulse_push(input eeprom_cmd_t c);
        @(posedge CLK);
        cmd      <= c;
        cmd_push <= 1'b1;
        @(posedge CLK);
        cmd_push <= 1'b0;
    endtask

    task automatic send_cmd(input eeprom_cmd_t c, input logic [7:0] exp_byte);
        eeprom_rd_t r;
        int         n;
        n = 0;
        @(negedge CLK);
        while (cmd_full && n < timeout_cycles)
        begin
            @(negedge CLK);
            n++;
        end
        if (cmd_full)
        begin
            errors++;
            $display("timeout: the command queue never had room for a new command");
        end
        else
        begin
            pulse_push(c);
            r.addr  = c.addr;
            r.rdata = exp_byte;
            if (!c.write)
                exp_q.push_back(r);
        end
    endtask

    // master idle for two samples with the command queue full
    task automatic wait_stalled();
        int   n;
        logic was_idle;
        n        = 0;
        was_idle = 1'b0;
        @(negedge CLK);
        while (!(idle && was_idle && cmd_full) && n < timeout_cycles)
        begin
            was_idle = idle;
            @(negedge CLK);
            n++;
        end
        if (n >= timeout_cycles)
        begin
            errors++;
            $display("timeout: the master did not stall on a full read queue");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        @(negedge CLK);
        while (!(exp_q.size() == 0 && idle && rd_empty && dut0.cmd_queue0.empty)
               && n < timeout_cycles)
        begin
            @(negedge CLK);
            n++;
        end
        if (n >= timeout_cycles)
        begin
            errors++;
            $display("timeout: outstanding commands did not finish, %0d reads pending",
                     exp_q.size());
        end
    endtask

    // drains read results in order while enabled
    always
    begin
        @(negedge CLK);
        if (!RESET && pop_enable && !rd_empty)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("a read result appeared with no read command outstanding");
            end
            else
                check_rd("rd_data", rd_data, exp_q.pop_front());
            @(posedge CLK);
            rd_pop <= 1'b1;
            @(posedge CLK);
            rd_pop <= 1'b0;
        end
    end

    initial
    begin
        eeprom_cmd_t c;
        int          n;
        CLK        = 1'b0;
        RESET      = 1'b1;
        cmd_push   = 1'b0;
        cmd        = '0;
        rd_pop     = 1'b0;
        pop_enable = 1'b0;
        seed       = 66;
        errors     = 0;
        checks     = 0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_bit("idle", idle, 1'b1);
        check_bit("rd_empty", rd_empty, 1'b1);
        check_bit("cmd_full", cmd_full, 1'b0);

        add_write(11'h155, 8'($random(seed)));
        add_read(11'h155);
        for (int i = 0; i < 8; i++)
        begin
            waddr[i] = {3'(i), 8'($random(seed))};  // every value of bits 10 to 8
            add_write(waddr[i], 8'($random(seed)));
        end
        for (int i = 0; i < 8; i++)
            add_read(waddr[(i * 3 + 5) % 8]);  // scrambled order
        add_write(waddr[2], ~model[waddr[2]]);
        add_read(waddr[2]);

        pop_enable = 1'b1;
        foreach (stim[i])
            send_cmd(stim[i].cmd, stim[i].exp);
        wait_drained();

        // back-pressure with the reader stopped
        pop_enable = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            c.write = 1'b0;
            c.addr  = waddr[i];
            c.wdata = 8'h00;
            send_cmd(c, model[c.addr]);
        end
        wait_stalled();
        for (n = 0; n < 400; n++)
        begin
            @(negedge CLK);
            if (!idle || !cmd_full || rd_empty)
            begin
                errors++;
                $display("the master moved on while the read queue was full");
                break;
            end
        end
        check_bit("cmd_full", cmd_full, 1'b1);
        pulse_push(c);  // dropped, queue is full
        pop_enable = 1'b1;
        wait_drained();
        repeat (400) @(negedge CLK);

        check_bit("idle", idle, 1'b1);
        check_bit("rd_empty", rd_empty, 1'b1);
        check_bit("cmd_full", cmd_full, 1'b0);
        check_bit("cmd_empty", dut0.cmd_queue0.empty, 1'b1);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
source/eeprom_pkg.sv
source/byte_queue.sv
source/eeprom_serial_master.sv
source/eeprom_device.sv
source/eeprom_subsystem.sv
testbench/eeprom_properties.sv
testbench/eeprom_tb.sv

// File: Bender.yml
package:
  name: eeprom_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/eeprom_pkg.sv
      - source/byte_queue.sv
      - source/eeprom_serial_master.sv
      - source/eeprom_device.sv
      - source/eeprom_subsystem.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/eeprom_properties.sv
      - testbench/eeprom_tb.sv
